//--- mm_stim.txt
// One record per line: op digit, then pegs of slots 0 to 3, one hex digit each
// op 1 = new code, 2 = guess, 3 = soft reset (pegs ignored)
1_1234
2_5670
2_4321
2_1243
2_1234
// Player two sets, four misses end the round
1_2215
2_2222
2_1522
2_5512
2_7777
1_0000
2_0700
3_0000
1_6363
2_3636
2_6633
2_6363
// Repeated colours and a full round of misses
1_7531
2_1357
2_7777
2_7530
2_0246
3_0000
1_4455
2_4455

//--- sources.f
mm_pkg.sv
game_fsm.sv
peg_store.sv
peg_scorer.sv
round_keeper.sv
seven_seg.sv
mastermind_top.sv
mastermind_chk.sv
tb_mastermind.sv

//--- run.sh
#!/bin/sh
# Build and run the Mastermind testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_mastermind -f sources.f -o sim_mastermind; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_mastermind > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -eq 0 ] && grep -q "RESULT: PASS" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed (exit status $status)"
exit 1

//--- tb_mastermind.sv
module tb_mastermind;

    localparam int TICK_DIV         = 2;
    localparam int MAX_GUESSES      = 4;
    localparam int MAX_RECORDS      = 64;
    localparam int TICKS_PER_RECORD = 40;

    // Active-low patterns with segment g in bit 6
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    logic                clock;
    logic                resetn;
    mm_pkg::peg_t        peg;
    logic                load;
    logic                soft_reset;
    mm_pkg::scoreboard_t board;
    mm_pkg::seg_bank_t   segments;

    logic [19:0]  stim_mem [MAX_RECORDS];
    mm_pkg::peg_t ref_code [mm_pkg::SLOTS];
    mm_pkg::peg_t guess_pegs [mm_pkg::SLOTS];
    int           one_score;
    int           two_score;
    int           one_sets;
    int           guess_count;
    int           err_count;
    int unsigned  lcg_state;
    int           n_rec;

    mastermind_top #(
        .TICK_DIV    (TICK_DIV),
        .MAX_GUESSES (MAX_GUESSES)
    ) i_mastermind_top (
        .clock        (clock),
        .resetn       (resetn),
        .peg_i        (peg),
        .load_i       (load),
        .soft_reset_i (soft_reset),
        .board_o      (board),
        .segments_o   (segments)
    );

    always #5 clock = ~clock;

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("FAILED at time %0t: %s expected %0h, got %0h", $time, what, expected, actual);
            stop_with_failure();
        end
    endtask

    function automatic int unsigned next_gap();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'd3;   // 0 to 3 idle clocks
    endfunction

    task automatic wait_ticks(int n);
        repeat (n * TICK_DIV) @(posedge clock);
    endtask

    // One press and one release of 3 ticks each
    task automatic enter_peg(mm_pkg::peg_t value);
        repeat (next_gap()) @(posedge clock);
        @(posedge clock);
        peg  <= value;
        load <= 1'b1;
        wait_ticks(3);
        load <= 1'b0;
        wait_ticks(3);
    endtask

    task automatic await_result();
        int waited;
        waited = 0;
        @(negedge clock);
        while (!i_mastermind_top.result_strobe) begin
            waited++;
            if (waited > 20 * TICK_DIV) begin
                $display("No result strobe after the guess at time %0t", $time);
                stop_with_failure();
            end
            @(negedge clock);
        end
        // Release seen within one tick of the load drop and scored 5 ticks later
        check_value("result 5 ticks after the last release", 1'b1,
                    (waited >= 2 * TICK_DIV) && (waited < 3 * TICK_DIV));
        @(negedge clock);   // Scoreboard updated on the strobe edge
    endtask

    // Shared colours counted by histogram and matched once each
    function automatic void reference_score(output int red, output int white);
        int code_hist [8];
        int guess_hist [8];
        int common;
        red    = 0;
        common = 0;
        for (int c = 0; c < 8; c++) begin
            code_hist[c]  = 0;
            guess_hist[c] = 0;
        end
        for (int s = 0; s < mm_pkg::SLOTS; s++) begin
            if (ref_code[s] == guess_pegs[s])
                red++;
            code_hist[ref_code[s]]++;
            guess_hist[guess_pegs[s]]++;
        end
        for (int c = 0; c < 8; c++)
            common += (code_hist[c] < guess_hist[c]) ? code_hist[c] : guess_hist[c];
        white = common - red;
    endfunction

    task automatic check_board(int red, int white);
        mm_pkg::seg_bank_t exp_seg;
        exp_seg.hex0 = SEG_TABLE[one_score];
        exp_seg.hex1 = SEG_TABLE[two_score];
        exp_seg.hex2 = SEG_TABLE[one_sets];
        exp_seg.hex4 = SEG_TABLE[red];
        exp_seg.hex5 = SEG_TABLE[white];
        check_value("red", red, board.feedback.red);
        check_value("white", white, board.feedback.white);
        check_value("guess_count", guess_count, board.guess_count);
        check_value("one_score", one_score, board.one_score);
        check_value("two_score", two_score, board.two_score);
        check_value("one_sets_code", one_sets, board.one_sets_code);
        check_value("segments", exp_seg, segments);
    endtask

    initial begin
        logic [19:0] rec;
        int          red;
        int          white;
        clock       = 1'b0;
        resetn      = 1'b0;
        peg         = '0;
        load        = 1'b0;
        soft_reset  = 1'b1;
        lcg_state   = 29;
        one_score   = 0;
        two_score   = 0;
        one_sets    = 1;
        guess_count = 0;
        err_count   = 0;
        for (int i = 0; i < MAX_RECORDS; i++)
            stim_mem[i] = '0;
        $readmemh("mm_stim.txt", stim_mem);
        n_rec = 0;
        while ((n_rec < MAX_RECORDS) && (stim_mem[n_rec][19:16] != 4'h0))
            n_rec++;
        if (n_rec == 0) begin
            $display("No records found in mm_stim.txt");
            stop_with_failure();
        end
        repeat (3) @(posedge clock);
        resetn <= 1'b1;
        fork
            begin
                #(n_rec * TICKS_PER_RECORD * TICK_DIV * 10);
                $display("Watchdog expired after %0d records worth of ticks", n_rec);
                stop_with_failure();
            end
        join_none
        @(negedge clock);
        check_board(0, 0);

        for (int r = 0; r < n_rec; r++) begin
            rec = stim_mem[r];
            for (int s = 0; s < mm_pkg::SLOTS; s++)
                guess_pegs[s] = rec[14 - 4 * s -: 3];
            case (rec[19:16])
                4'h1: begin
                    for (int s = 0; s < mm_pkg::SLOTS; s++) begin
                        enter_peg(guess_pegs[s]);
                        ref_code[s] = guess_pegs[s];
                    end
                end
                4'h2: begin
                    for (int s = 0; s < mm_pkg::SLOTS; s++)
                        enter_peg(guess_pegs[s]);
                    await_result();
                    reference_score(red, white);
                    if (red < mm_pkg::SLOTS) begin
                        if (one_sets == 1)
                            one_score++;
                        else
                            two_score++;
                    end
                    if ((red == mm_pkg::SLOTS) || (guess_count + 1 == MAX_GUESSES)) begin
                        guess_count = 0;
                        one_sets    = 1 - one_sets;   // Roles swap at the round end
                    end else begin
                        guess_count++;
                    end
                    check_board(red, white);
                end
                4'h3: begin
                    @(posedge clock);
                    soft_reset <= 1'b0;
                    wait_ticks(2);
                    soft_reset <= 1'b1;
                    guess_count = 0;
                    one_sets    = 1 - one_sets;
                    @(negedge clock);
                    check_board(0, 0);
                end
                default: begin
                    $display("Unknown operation %0h in record %0d", rec[19:16], r);
                    stop_with_failure();
                end
            endcase
        end

        if (err_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

//--- mastermind_chk.sv
module mastermind_chk (
    input logic clock,
    input logic resetn,
    input logic soft_reset_i,
    input logic code_we_i,
    input logic guess_we_i,
    input logic score_step_i,
    input logic result_strobe_i
);

    logic [2:0] steps_seen;

    // Score steps since the last result
    always_ff @(posedge clock) begin
        if (!resetn || !soft_reset_i)
            steps_seen <= '0;
        else if (result_strobe_i)
            steps_seen <= '0;
        else if (score_step_i)
            steps_seen <= steps_seen + 1'b1;
    end

    strobe_onehot: assert property (@(posedge clock) disable iff (!resetn)
        $onehot0({code_we_i, guess_we_i, score_step_i, result_strobe_i}))
        else $error("More than one game strobe high in the same cycle");

    result_after_steps: assert property (@(posedge clock) disable iff (!resetn || !soft_reset_i)
        result_strobe_i |-> (steps_seen == 3'd4))
        else $error("Result strobe without exactly four score steps before it");

    steps_bounded: assert property (@(posedge clock) disable iff (!resetn || !soft_reset_i)
        score_step_i |-> (steps_seen < 3'd4))
        else $error("More than four score steps before a result");

    quiet_in_reset: assert property (@(posedge clock)
        !resetn |-> !(code_we_i || guess_we_i || score_step_i || result_strobe_i))
        else $error("Game strobe high while reset is asserted");

endmodule

bind game_fsm mastermind_chk i_mastermind_chk (
    .clock           (clock),
    .resetn          (resetn),
    .soft_reset_i    (soft_reset_i),
    .code_we_i       (code_we_o),
    .guess_we_i      (guess_we_o),
    .score_step_i    (score_step_o),
    .result_strobe_i (result_strobe_o)
);

//--- mastermind_top.sv
module mastermind_top #(
    parameter int TICK_DIV    = 1000000,
    parameter int MAX_GUESSES = 8
) (
    input  logic                clock,
    input  logic                resetn,
    input  mm_pkg::peg_t        peg_i,
    input  logic                load_i,
    input  logic                soft_reset_i,
    output mm_pkg::scoreboard_t board_o,
    output mm_pkg::seg_bank_t   segments_o
);

    logic              code_we;
    logic              guess_we;
    mm_pkg::slot_t     slot;
    logic              score_step;
    logic              result_strobe;
    logic              round_end;
    mm_pkg::row_t      code;
    mm_pkg::row_t      guess;
    mm_pkg::feedback_t feedback;

    game_fsm #(
        .TICK_DIV (TICK_DIV)
    ) i_game_fsm (
        .clock           (clock),
        .resetn          (resetn),
        .load_i          (load_i),
        .soft_reset_i    (soft_reset_i),
        .round_end_i     (round_end),
        .code_we_o       (code_we),
        .guess_we_o      (guess_we),
        .slot_o          (slot),
        .score_step_o    (score_step),
        .result_strobe_o (result_strobe)
    );

    peg_store i_peg_store (
        .clock        (clock),
        .resetn       (resetn),
        .soft_reset_i (soft_reset_i),
        .peg_i        (peg_i),
        .code_we_i    (code_we),
        .guess_we_i   (guess_we),
        .slot_i       (slot),
        .code_o       (code),
        .guess_o      (guess)
    );

    peg_scorer i_peg_scorer (
        .clock        (clock),
        .resetn       (resetn),
        .soft_reset_i (soft_reset_i),
        .step_i       (score_step),
        .slot_i       (slot),
        .code_i       (code),
        .guess_i      (guess),
        .feedback_o   (feedback)
    );

    round_keeper #(
        .MAX_GUESSES (MAX_GUESSES)
    ) i_round_keeper (
        .clock        (clock),
        .resetn       (resetn),
        .soft_reset_i (soft_reset_i),
        .result_i     (result_strobe),
        .feedback_i   (feedback),
        .round_end_o  (round_end),
        .board_o      (board_o)
    );

    seven_seg i_seg_hex0 (.digit_i(board_o.one_score), .seg_o(segments_o.hex0));
    seven_seg i_seg_hex1 (.digit_i(board_o.two_score), .seg_o(segments_o.hex1));
    seven_seg i_seg_hex2 (.digit_i({3'b000, board_o.one_sets_code}), .seg_o(segments_o.hex2));
    seven_seg i_seg_hex4 (.digit_i({1'b0, feedback.red}), .seg_o(segments_o.hex4));
    seven_seg i_seg_hex5 (.digit_i({1'b0, feedback.white}), .seg_o(segments_o.hex5));

endmodule

//--- seven_seg.sv
module seven_seg (
    input  logic [3:0]               digit_i,
    output logic [mm_pkg::SEG_W-1:0] seg_o
);

    // Segment g in the top bit, low lights the segment
    always_comb begin
        case (digit_i)
            4'h0:    seg_o = 7'b100_0000;
            4'h1:    seg_o = 7'b111_1001;
            4'h2:    seg_o = 7'b010_0100;
            4'h3:    seg_o = 7'b011_0000;
            4'h4:    seg_o = 7'b001_1001;
            4'h5:    seg_o = 7'b001_0010;
            4'h6:    seg_o = 7'b000_0010;
            4'h7:    seg_o = 7'b111_1000;
            4'h8:    seg_o = 7'b000_0000;
            4'h9:    seg_o = 7'b001_1000;
            4'hA:    seg_o = 7'b000_1000;
            4'hB:    seg_o = 7'b000_0011;
            4'hC:    seg_o = 7'b100_0110;
            4'hD:    seg_o = 7'b010_0001;
            4'hE:    seg_o = 7'b000_0110;
            4'hF:    seg_o = 7'b000_1110;
            default: seg_o = 7'b111_1111;
        endcase
    end

endmodule

//--- round_keeper.sv
module round_keeper #(
    parameter int MAX_GUESSES = 8
) (
    input  logic                clock,
    input  logic                resetn,
    input  logic                soft_reset_i,
    input  logic                result_i,
    input  mm_pkg::feedback_t   feedback_i,
    output logic                round_end_o,
    output mm_pkg::scoreboard_t board_o
);

    logic [mm_pkg::COUNT_W-1:0] guess_count;
    logic [mm_pkg::SCORE_W-1:0] one_score;
    logic [mm_pkg::SCORE_W-1:0] two_score;
    logic                       one_sets_code;
    logic                       soft_q;
    logic                       soft_fall;
    logic                       miss;

    assign soft_fall   = soft_q && !soft_reset_i;
    assign miss        = (int'(feedback_i.red) != mm_pkg::SLOTS);
    assign round_end_o = !miss || ((int'(guess_count) + 1) == MAX_GUESSES);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            guess_count   <= '0;
            one_score     <= '0;
            two_score     <= '0;
            one_sets_code <= 1'b1;
            soft_q        <= 1'b1;
        end else begin
            soft_q <= soft_reset_i;
            if (!soft_reset_i) begin
                guess_count <= '0;
                if (soft_fall)
                    one_sets_code <= !one_sets_code;   // Roles swap once per press
            end else if (result_i) begin
                // Setter earns a point for every missed guess
                if (miss) begin
                    if (one_sets_code)
                        one_score <= one_score + 1'b1;
                    else
                        two_score <= two_score + 1'b1;
                end
                if (round_end_o) begin
                    guess_count   <= '0;
                    one_sets_code <= !one_sets_code;
                end else begin
                    guess_count <= guess_count + 1'b1;
                end
            end
        end
    end

    always_comb begin
        board_o.feedback      = feedback_i;
        board_o.guess_count   = guess_count;
        board_o.one_score     = one_score;
        board_o.two_score     = two_score;
        board_o.one_sets_code = one_sets_code;
    end

endmodule

//--- peg_scorer.sv
module peg_scorer (
    input  logic              clock,
    input  logic              resetn,
    input  logic              soft_reset_i,
    input  logic              step_i,
    input  mm_pkg::slot_t     slot_i,
    input  mm_pkg::row_t      code_i,
    input  mm_pkg::row_t      guess_i,
    output mm_pkg::feedback_t feedback_o
);

    mm_pkg::feedback_t       fb_q;
    mm_pkg::feedback_t       fb_base;
    mm_pkg::feedback_t       fb_nxt;
    logic [mm_pkg::SLOTS-1:0] used_q;
    logic [mm_pkg::SLOTS-1:0] used_base;
    logic [mm_pkg::SLOTS-1:0] used_nxt;
    logic [mm_pkg::SLOTS-1:0] exact;
    mm_pkg::peg_t            code_peg;
    logic                    found;

    always_comb begin
        for (int j = 0; j < mm_pkg::SLOTS; j++) begin
            exact[j] = (code_i[j] == guess_i[j]);
        end
    end

    always_comb begin
        code_peg = code_i[slot_i];

        // Step 0 starts a fresh count
        if (slot_i == 2'd0) begin
            fb_base   = '0;
            used_base = '0;
        end else begin
            fb_base   = fb_q;
            used_base = used_q;
        end

        fb_nxt   = fb_base;
        used_nxt = used_base;
        found    = 1'b0;

        if (exact[slot_i]) begin
            fb_nxt.red = fb_base.red + 1'b1;
        end else begin
            // Lowest free guess peg of this colour that is not a red itself
            for (int j = 0; j < mm_pkg::SLOTS; j++) begin
                if (!found && !used_base[j] && !exact[j] && (guess_i[j] == code_peg)) begin
                    found       = 1'b1;
                    used_nxt[j] = 1'b1;
                end
            end
            if (found)
                fb_nxt.white = fb_base.white + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn || !soft_reset_i) begin
            fb_q   <= '0;
            used_q <= '0;
        end else if (step_i) begin
            fb_q   <= fb_nxt;
            used_q <= used_nxt;
        end
    end

    assign feedback_o = fb_q;   // Held until the next guess's step 0

endmodule

//--- peg_store.sv
module peg_store (
    input  logic          clock,
    input  logic          resetn,
    input  logic          soft_reset_i,
    input  mm_pkg::peg_t  peg_i,
    input  logic          code_we_i,
    input  logic          guess_we_i,
    input  mm_pkg::slot_t slot_i,
    output mm_pkg::row_t  code_o,
    output mm_pkg::row_t  guess_o
);

    mm_pkg::row_t code_q;
    mm_pkg::row_t guess_q;

    always_ff @(posedge clock) begin
        if (!resetn || !soft_reset_i) begin
            code_q  <= '0;
            guess_q <= '0;
        end else begin
            if (code_we_i) begin
                code_q[slot_i] <= peg_i;
                if (slot_i == 2'd0)
                    guess_q <= '0;   // First peg of a new code
            end
            if (guess_we_i)
                guess_q[slot_i] <= peg_i;
        end
    end

    assign code_o  = code_q;
    assign guess_o = guess_q;

endmodule

//--- game_fsm.sv
module game_fsm #(
    parameter int TICK_DIV = 1000000
) (
    input  logic          clock,
    input  logic          resetn,
    input  logic          load_i,
    input  logic          soft_reset_i,
    input  logic          round_end_i,
    output logic          code_we_o,
    output logic          guess_we_o,
    output mm_pkg::slot_t slot_o,
    output logic          score_step_o,
    output logic          result_strobe_o
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0]   tick_cnt;
    logic               tick;
    mm_pkg::fsm_state_t state;
    mm_pkg::fsm_state_t state_nxt;
    mm_pkg::slot_t      slot;
    logic               slot_advance;

    // Game tick, one clock wide every TICK_DIV clocks
    always_ff @(posedge clock) begin
        if (!resetn) begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end else if (tick_cnt == CNT_W'(TICK_DIV - 1)) begin
            tick_cnt <= '0;
            tick     <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            tick     <= 1'b0;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            mm_pkg::CODE_PRESS: begin
                if (load_i)
                    state_nxt = mm_pkg::CODE_RELEASE;
            end
            mm_pkg::CODE_RELEASE: begin
                if (!load_i)
                    state_nxt = (slot == 2'd3) ? mm_pkg::GUESS_PRESS : mm_pkg::CODE_PRESS;
            end
            mm_pkg::GUESS_PRESS: begin
                if (load_i)
                    state_nxt = mm_pkg::GUESS_RELEASE;
            end
            mm_pkg::GUESS_RELEASE: begin
                if (!load_i)
                    state_nxt = (slot == 2'd3) ? mm_pkg::SCORING : mm_pkg::GUESS_PRESS;
            end
            mm_pkg::SCORING: begin
                if (slot == 2'd3)
                    state_nxt = mm_pkg::RESULT;
            end
            mm_pkg::RESULT: begin
                state_nxt = round_end_i ? mm_pkg::CODE_PRESS : mm_pkg::GUESS_PRESS;
            end
            default: state_nxt = mm_pkg::CODE_PRESS;
        endcase
    end

    // Slot moves on each release and each scoring step, wraps to 0 after slot 3
    assign slot_advance = (((state == mm_pkg::CODE_RELEASE) ||
                            (state == mm_pkg::GUESS_RELEASE)) && !load_i) ||
                          (state == mm_pkg::SCORING);

    always_ff @(posedge clock) begin
        if (!resetn || !soft_reset_i) begin
            state <= mm_pkg::CODE_PRESS;
            slot  <= '0;
        end else if (tick) begin
            state <= state_nxt;
            if (slot_advance)
                slot <= slot + 1'b1;
        end
    end

    assign code_we_o       = tick && (state == mm_pkg::CODE_PRESS) && load_i;
    assign guess_we_o      = tick && (state == mm_pkg::GUESS_PRESS) && load_i;
    assign score_step_o    = tick && (state == mm_pkg::SCORING);
    assign result_strobe_o = tick && (state == mm_pkg::RESULT);
    assign slot_o          = slot;

endmodule

//--- mm_pkg.sv
package mm_pkg;

    localparam int PEG_W   = 3;
    localparam int SLOTS   = 4;
    localparam int COUNT_W = 3;
    localparam int SCORE_W = 4;
    localparam int SEG_W   = 7;

    typedef logic [PEG_W-1:0] peg_t;

    // Slot 0 is the first peg entered
    typedef peg_t [SLOTS-1:0] row_t;

    typedef logic [1:0] slot_t;

    typedef enum logic [2:0] {
        CODE_PRESS,
        CODE_RELEASE,
        GUESS_PRESS,
        GUESS_RELEASE,
        SCORING,
        RESULT
    } fsm_state_t;

    typedef struct packed {
        logic [COUNT_W-1:0] red;
        logic [COUNT_W-1:0] white;
    } feedback_t;

    typedef struct packed {
        feedback_t          feedback;
        logic [COUNT_W-1:0] guess_count;
        logic [SCORE_W-1:0] one_score;
        logic [SCORE_W-1:0] two_score;
        logic               one_sets_code;   // High while player one holds the code
    } scoreboard_t;

    // Active-low segment patterns, hex0 in the low bits
    typedef struct packed {
        logic [SEG_W-1:0] hex5;
        logic [SEG_W-1:0] hex4;
        logic [SEG_W-1:0] hex2;
        logic [SEG_W-1:0] hex1;
        logic [SEG_W-1:0] hex0;
    } seg_bank_t;

endpackage
